// ==== source/mole_geometry_pkg.sv ====
// Playfield geometry: coordinate, tile, mole set and pointer types
// Grid size, tile placement constants and tile origin helper
package mole_geometry_pkg;

  //////////////////////////////////////////////////////////////////////
  // Grid and tile constants
  //////////////////////////////////////////////////////////////////////
  localparam int grid_cols   = 4;    // Tiles across
  localparam int grid_rows   = 3;    // Tiles down
  localparam int tile_pitch  = 160;  // Distance between tile origins
  localparam int tile_offset = 40;   // Origin of tile 0 on either axis
  localparam int tile_size   = 80;   // Square edge, half-open range

  typedef logic [9:0] coord_t;       // Screen coordinate

  typedef struct packed {
    logic [1:0] col;
    logic [1:0] row;
  } tile_t;

  // Producer output, second equals first for a single mole
  typedef struct packed {
    tile_t first;
    tile_t second;
    logic  decoy;                    // Second mole is a decoy
    logic  valid;                    // Set from the first round on
  } mole_set_t;

  // Tracked object position
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   present;                 // Object seen this cycle
  } pointer_t;

  // Origin of a tile on one axis
  function automatic coord_t tile_origin(input logic [1:0] index);
    return coord_t'(index * tile_pitch + tile_offset);
  endfunction

endpackage

// ==== source/mole_score_pkg.sv ====
// Scoring types: score, level and per-round hit summary
// Score steps, penalties and the level ceiling
package mole_score_pkg;

  //////////////////////////////////////////////////////////////////////
  // Score and level
  //////////////////////////////////////////////////////////////////////
  typedef logic [7:0] score_t;
  typedef logic [2:0] level_t;

  localparam level_t max_level = 3'd7;    // Level saturates here

  //////////////////////////////////////////////////////////////////////
  // Round result, produced by the hit latch
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic first_hit;     // Pointer reached the first tile
    logic second_hit;    // Pointer reached the second tile only
    logic decoy;         // Second mole of the round was a decoy
    logic same_tile;     // Both moles share one tile
  } round_hits_t;

  // Rewards
  localparam score_t bonus_both   = 8'd2;  // Two real moles on distinct tiles
  localparam score_t bonus_single = 8'd1;  // One real mole

  // Penalties, floor at zero
  localparam score_t penalty_with_real  = 8'd4;  // Real mole plus decoy
  localparam score_t penalty_decoy_only = 8'd5;  // Decoy alone

  // Saturating subtract
  function automatic score_t score_minus(input score_t value, input score_t amount);
    return (value > amount) ? score_t'(value - amount) : '0;
  endfunction

endpackage

// ==== source/mole_placer.sv ====
// Mole placer: round timer, three LFSR generators, mole placement
// Emits the round strobe together with the new mole set
module mole_placer
#(
  parameter int unsigned round_cycles_base = 2**20  // Level-0 round length
)
(
  input  logic                         clock,
  input  logic                         reset,
  input  mole_score_pkg::level_t       level,        // Shortens the round
  output mole_geometry_pkg::mole_set_t moles,
  output logic                         round_start   // One-cycle strobe
);

  localparam int count_width = $clog2(round_cycles_base + 1);

  // Generator seeds
  localparam logic [30:0] lfsr_seed [3] = '{31'h5555_5555, 31'h6666_6666, 31'h5777_7777};

  logic [count_width-1:0] count;       // Cycles left in the round
  logic [count_width-1:0] period;      // Round length at this level
  logic [30:0]            gen [3];     // Random generators
  logic                   two_moles;
  mole_geometry_pkg::mole_set_t next_moles;

  // One step of a 31-bit Fibonacci LFSR, taps 31 and 28
  function automatic logic [30:0] lfsr_step(input logic [30:0] value);
    return {value[29:0], value[27] ^ value[30]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Round timer
  //////////////////////////////////////////////////////////////////////
  assign period = count_width'(round_cycles_base >> level);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      count       <= count_width'(round_cycles_base - 1);  // Level 0 after reset
      round_start <= 1'b0;
    end
    else if (count == '0)
    begin
      count       <= period - 1'b1;    // Next round at current level
      round_start <= 1'b1;
    end
    else
    begin
      count       <= count - 1'b1;
      round_start <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random generators, free running
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    for (int i = 0; i < 3; i++)
    begin
      if (reset)
        gen[i] <= lfsr_seed[i];
      else
        gen[i] <= lfsr_step(gen[i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Placement
  //////////////////////////////////////////////////////////////////////
  assign two_moles = gen[0][30];      // Half the rounds show two moles

  always_comb
  begin
    next_moles.first.col  = 2'(gen[0][7:0] % mole_geometry_pkg::grid_cols);
    next_moles.first.row  = 2'(gen[2][7:0] % mole_geometry_pkg::grid_rows);
    next_moles.second.col = 2'(gen[1][7:0] % mole_geometry_pkg::grid_cols);
    next_moles.second.row = 2'(gen[2][15:8] % mole_geometry_pkg::grid_rows);
    next_moles.decoy      = two_moles & gen[1][4];
    next_moles.valid      = 1'b1;
    if (!two_moles)
      next_moles.second = next_moles.first;  // Single mole, no decoy
  end

  // New set appears with the strobe, held for the whole round
  always_ff @(posedge clock)
  begin
    if (reset)
      moles <= '0;
    else if (count == '0)
      moles <= next_moles;
  end

  // Strobe is a single pulse
  assert property (@(posedge clock) disable iff (reset) round_start |=> !round_start);

  // Rows stay on the grid once moles are shown
  assert property (@(posedge clock) disable iff (reset)
    moles.valid |-> (moles.first.row < mole_geometry_pkg::grid_rows) &&
                    (moles.second.row < mole_geometry_pkg::grid_rows));

endmodule

// ==== source/hit_latch.sv ====
// Hit latch: pointer versus mole tile test
// Holds the hit flags of the running round until the strobe
module hit_latch
(
  input  logic                         clock,
  input  logic                         reset,
  input  mole_geometry_pkg::mole_set_t moles,
  input  logic                         round_start,
  input  mole_geometry_pkg::pointer_t  pointer,
  output mole_score_pkg::round_hits_t  hits         // Valid with round_start
);

  mole_score_pkg::round_hits_t held;   // Result of the running round
  logic                        sample; // Pointer usable this cycle
  logic                        in_first;
  logic                        in_second;

  // Half-open square test on both axes
  function automatic logic in_tile(input mole_geometry_pkg::pointer_t p,
                                   input mole_geometry_pkg::tile_t    t);
    mole_geometry_pkg::coord_t x0;
    mole_geometry_pkg::coord_t y0;
    x0 = mole_geometry_pkg::tile_origin(t.col);
    y0 = mole_geometry_pkg::tile_origin(t.row);
    return (p.x >= x0) && (p.x < x0 + mole_geometry_pkg::tile_size) &&
           (p.y >= y0) && (p.y < y0 + mole_geometry_pkg::tile_size);
  endfunction

  assign sample    = moles.valid && pointer.present;
  assign in_first  = in_tile(pointer, moles.first);
  assign in_second = in_tile(pointer, moles.second);

  //////////////////////////////////////////////////////////////////////
  // Round hit flags
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
      held <= '0;
    else if (round_start)
    begin
      // New round, take the round attributes from the new set
      held.first_hit  <= 1'b0;
      held.second_hit <= 1'b0;
      held.decoy      <= moles.decoy;
      held.same_tile  <= (moles.first == moles.second);
    end
    else if (sample)
    begin
      if (in_first)
        held.first_hit <= 1'b1;     // First tile wins on overlap
      else if (in_second)
        held.second_hit <= 1'b1;
    end
  end

  assign hits = held;   // Still the finished round during the strobe

endmodule

// ==== source/score_keeper.sv ====
// Score keeper with per-round scoring, clear and level advance
// Score resets to zero on each level up
module score_keeper
#(
  parameter int unsigned level_up_score = 15   // Score that advances the level
)
(
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        round_start,
  input  mole_score_pkg::round_hits_t hits,
  input  logic                        clear,
  output mole_score_pkg::score_t      score,
  output mole_score_pkg::level_t      level,
  output logic                        level_up     // One-cycle pulse
);

  mole_score_pkg::score_t round_score;  // Score after this round's rules
  logic                   both;
  logic                   only_first;
  logic                   only_second;

  assign both        = hits.first_hit & hits.second_hit;
  assign only_first  = hits.first_hit & ~hits.second_hit;
  assign only_second = ~hits.first_hit & hits.second_hit;

  //////////////////////////////////////////////////////////////////////
  // Round rules in priority order
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (both && !hits.same_tile && !hits.decoy)
      round_score = score + mole_score_pkg::bonus_both;      // Two real moles
    else if (only_first || (only_second && !hits.decoy) || (both && hits.same_tile))
      round_score = score + mole_score_pkg::bonus_single;    // One real mole
    else if (both && hits.decoy)
      round_score = mole_score_pkg::score_minus(score, mole_score_pkg::penalty_with_real);
    else if (only_second && hits.decoy)
      round_score = mole_score_pkg::score_minus(score, mole_score_pkg::penalty_decoy_only);
    else
      round_score = score;                                   // Missed round
  end

  //////////////////////////////////////////////////////////////////////
  // Score and level registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      score    <= '0;
      level    <= '0;
      level_up <= 1'b0;
    end
    else
    begin
      level_up <= 1'b0;
      if (clear)
        score <= '0;                      // Clear beats the round update
      else if (round_start)
      begin
        if (round_score >= level_up_score)
        begin
          score    <= '0;
          level_up <= 1'b1;               // Pulses at max level too
          if (level != mole_score_pkg::max_level)
            level <= level + 1'b1;
        end
        else
          score <= round_score;
      end
    end
  end

  // Threshold is never held
  assert property (@(posedge clock) disable iff (reset) score < level_up_score);

endmodule

// ==== source/whack_a_mole.sv ====
// Whack-a-mole game top: mole placer, hit latch and score keeper
module whack_a_mole
#(
  parameter int unsigned round_cycles_base = 2**20,  // Level-0 round in clocks
  parameter int unsigned level_up_score    = 15      // Score for next level
)
(
  input  logic                         clock,
  input  logic                         reset,
  input  mole_geometry_pkg::pointer_t  pointer,     // Tracked object
  input  logic                         clear,       // Score clear request
  output mole_geometry_pkg::mole_set_t moles,
  output logic                         round_start,
  output mole_score_pkg::score_t       score,
  output mole_score_pkg::level_t       level,
  output logic                         level_up
);

  mole_score_pkg::round_hits_t hits;   // Latch to scorer

  //////////////////////////////////////////////////////////////////////
  // Producer
  //////////////////////////////////////////////////////////////////////
  mole_placer #(
    .round_cycles_base (round_cycles_base)
  ) i_mole_placer (
    .clock       (clock),
    .reset       (reset),
    .level       (level),       // Fed back from the scorer
    .moles       (moles),
    .round_start (round_start)
  );

  // Buffer
  hit_latch i_hit_latch (
    .clock       (clock),
    .reset       (reset),
    .moles       (moles),
    .round_start (round_start),
    .pointer     (pointer),
    .hits        (hits)
  );

  // Consumer
  score_keeper #(
    .level_up_score (level_up_score)
  ) i_score_keeper (
    .clock       (clock),
    .reset       (reset),
    .round_start (round_start),
    .hits        (hits),
    .clear       (clear),
    .score       (score),
    .level       (level),
    .level_up    (level_up)
  );

endmodule

// ==== tests/whack_a_mole_checks.svh ====
// Typed compare tasks for score, level, level_up and mole tiles
// Failure report that ends the run
`ifndef WHACK_A_MOLE_CHECKS_SVH
`define WHACK_A_MOLE_CHECKS_SVH

// Print the reason and end the run
task automatic report_failure(input string what);
  $display("%s", what);
  $display("TB FAILED");
  $fatal(1, "Run stopped at the first error");
endtask

task automatic check_score(input mole_score_pkg::score_t actual,
                           input mole_score_pkg::score_t expected);
  if (actual !== expected)
    report_failure($sformatf("CHECK FAILED at %0t: score = %0d, expected %0d",
                             $time, actual, expected));
endtask

task automatic check_level(input mole_score_pkg::level_t actual,
                           input mole_score_pkg::level_t expected);
  if (actual !== expected)
    report_failure($sformatf("CHECK FAILED at %0t: level = %0d, expected %0d",
                             $time, actual, expected));
endtask

task automatic check_level_up(input logic actual, input logic expected);
  if (actual !== expected)
    report_failure($sformatf("CHECK FAILED at %0t: level_up = %b, expected %b",
                             $time, actual, expected));
endtask

// Tile held for the whole round
task automatic check_tile(input string name,
                          input mole_geometry_pkg::tile_t actual,
                          input mole_geometry_pkg::tile_t expected);
  if (actual !== expected)
    report_failure($sformatf("CHECK FAILED at %0t: %s = col %0d row %0d, expected col %0d row %0d",
                             $time, name, actual.col, actual.row,
                             expected.col, expected.row));
endtask

`endif

// ==== tests/whack_a_mole_tb.sv ====
// Whack-a-mole testbench with trace driven rounds and a reference score model
// Clock, reset, pointer driver, strobe timing checks and watchdog
module whack_a_mole_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned round_base   = 256;  // Level-0 round in clocks
  localparam int unsigned level_target = 15;   // Score that advances the level
  localparam int          hold_cycles  = 10;   // Pointer dwell per tile
  localparam int          action_none   = 0;
  localparam int          action_first  = 1;
  localparam int          action_second = 2;
  localparam int          action_both   = 3;

  logic                         clock;
  logic                         reset;
  mole_geometry_pkg::pointer_t  pointer;
  logic                         clear;
  mole_geometry_pkg::mole_set_t moles;
  logic                         round_start;
  mole_score_pkg::score_t       score;
  mole_score_pkg::level_t       level;
  logic                         level_up;

  int     actions [$];              // Pointer action per round
  bit     clears [$];               // Clear request per round
  bit     trace_loaded = 1'b0;
  int     cycle_count  = 0;         // Rising edges so far
  integer seed         = 32'h23aa;

  // Reference model
  mole_score_pkg::score_t      exp_score    = '0;
  mole_score_pkg::level_t      exp_level    = '0;
  logic                        exp_level_up = 1'b0;
  mole_score_pkg::round_hits_t exp_hits     = '0;  // Hits of the running round
  int                          penalties    = 0;   // Decoy penalties applied

  `include "whack_a_mole_checks.svh"

  whack_a_mole #(
    .round_cycles_base (round_base),
    .level_up_score    (level_target)
  ) i_whack_a_mole (
    .clock       (clock),
    .reset       (reset),
    .pointer     (pointer),
    .clear       (clear),
    .moles       (moles),
    .round_start (round_start),
    .score       (score),
    .level       (level),
    .level_up    (level_up)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;   // 100 ns period
  end

  always @(posedge clock)
    cycle_count <= cycle_count + 1;

  ////////////////////////////////////////////////////////////////////
  // Trace reader
  ////////////////////////////////////////////////////////////////////
  task automatic load_trace();
    int           fd;
    int           fields;
    int           clr;
    logic [639:0] text_line;
    logic [63:0]  word;
    fd = $fopen("tests/round_trace.txt", "r");
    if (fd == 0)
      report_failure("Cannot open the round trace tests/round_trace.txt");
    while ($fgets(text_line, fd) != 0)
    begin
      word = '0;
      clr  = 0;
      fields = $sscanf(text_line, "%s %d", word, clr);
      if (fields < 1 || word == "#")
        continue;                          // Blank or comment line
      if (fields != 2)
        report_failure("Round trace line without a clear flag");
      case (word)
        "none":   actions.push_back(action_none);
        "first":  actions.push_back(action_first);
        "second": actions.push_back(action_second);
        "both":   actions.push_back(action_both);
        default:  report_failure("Unknown pointer action in the round trace");
      endcase
      clears.push_back(clr != 0);
    end
    $fclose(fd);
    if (actions.size() == 0)
      report_failure("Round trace holds no rounds");
  endtask

  // Half-open tile square on both axes
  function automatic bit inside_tile(input int x, input int y,
                                     input mole_geometry_pkg::tile_t t);
    int left;
    int top;
    left = t.col * mole_geometry_pkg::tile_pitch + mole_geometry_pkg::tile_offset;
    top  = t.row * mole_geometry_pkg::tile_pitch + mole_geometry_pkg::tile_offset;
    return (x >= left) && (x < left + mole_geometry_pkg::tile_size) &&
           (y >= top) && (y < top + mole_geometry_pkg::tile_size);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Pointer driver
  ////////////////////////////////////////////////////////////////////
  task automatic hold_pointer(input mole_geometry_pkg::tile_t t, input logic seen,
                              input mole_geometry_pkg::mole_set_t m);
    int px;
    int py;
    px = t.col * mole_geometry_pkg::tile_pitch + mole_geometry_pkg::tile_offset +
         int'($unsigned($random(seed)) % mole_geometry_pkg::tile_size);
    py = t.row * mole_geometry_pkg::tile_pitch + mole_geometry_pkg::tile_offset +
         int'($unsigned($random(seed)) % mole_geometry_pkg::tile_size);
    pointer.x       = mole_geometry_pkg::coord_t'(px);
    pointer.y       = mole_geometry_pkg::coord_t'(py);
    pointer.present = seen;
    if (seen)
    begin
      if (inside_tile(px, py, m.first))
        exp_hits.first_hit = 1'b1;          // First tile takes priority
      else if (inside_tile(px, py, m.second))
        exp_hits.second_hit = 1'b1;
    end
    repeat (hold_cycles) @(negedge clock);
  endtask

  task automatic play_round(input mole_geometry_pkg::mole_set_t m, input int action,
                            input bit do_clear);
    exp_hits           = '0;
    exp_hits.decoy     = m.decoy;
    exp_hits.same_tile = (m.first == m.second);
    case (action)
      action_first:  hold_pointer(m.first, 1'b1, m);
      action_second: hold_pointer(m.second, 1'b1, m);
      action_both:
      begin
        hold_pointer(m.first, 1'b1, m);
        hold_pointer(m.second, 1'b1, m);
      end
      default:       hold_pointer(m.first, 1'b0, m);  // On a mole but not seen
    endcase
    pointer.present = 1'b0;
    check_tile("moles.first", moles.first, m.first);
    check_tile("moles.second", moles.second, m.second);
    if (do_clear)
    begin
      clear = 1'b1;
      @(negedge clock);
      clear     = 1'b0;
      exp_score = '0;
      check_score(score, exp_score);      // Cleared one cycle after sampling
    end
  endtask

  // Rules of one finished round
  task automatic score_round(input mole_score_pkg::round_hits_t h);
    int gain;
    int new_score;
    gain = 0;
    if (h.first_hit && h.second_hit)
    begin
      if (h.same_tile)
        gain = int'(mole_score_pkg::bonus_single);
      else if (h.decoy)
        gain = -int'(mole_score_pkg::penalty_with_real);
      else
        gain = int'(mole_score_pkg::bonus_both);
    end
    else if (h.first_hit)
      gain = int'(mole_score_pkg::bonus_single);
    else if (h.second_hit)
      gain = h.decoy ? -int'(mole_score_pkg::penalty_decoy_only) :
                       int'(mole_score_pkg::bonus_single);
    if (gain < 0)
      penalties++;
    new_score = int'(exp_score) + gain;
    if (new_score < 0)
      new_score = 0;                      // Floor at zero
    exp_level_up = (new_score >= int'(level_target));
    if (exp_level_up)
    begin
      new_score = 0;
      if (exp_level != mole_score_pkg::max_level)
        exp_level = exp_level + 1'b1;
    end
    exp_score = mole_score_pkg::score_t'(new_score);
  endtask

  task automatic wait_strobe();
    int waited;
    waited = 0;
    @(negedge clock);
    while (!round_start)
    begin
      check_level_up(level_up, 1'b0);
      check_score(score, exp_score);      // Held between strobes
      waited++;
      if (waited > int'(round_base))
        report_failure($sformatf("No round_start within %0d cycles", round_base));
      @(negedge clock);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////
  initial
  begin : stimulus
    mole_geometry_pkg::mole_set_t cur;
    int release_cycle;
    int last_strobe;
    int expected_gap;
    int n_rounds;
    reset   = 1'b1;
    clear   = 1'b0;
    pointer = '0;
    load_trace();
    n_rounds     = actions.size();
    trace_loaded = 1'b1;
    repeat (8) @(negedge clock);
    reset         = 1'b0;
    release_cycle = cycle_count;
    // Quiet until the first strobe
    @(negedge clock);
    while (!round_start)
    begin
      check_level_up(level_up, 1'b0);
      check_score(score, '0);
      check_level(level, '0);
      if (moles.valid)
        report_failure("moles.valid went high before the first round_start");
      @(negedge clock);
    end
    if (cycle_count - release_cycle != int'(round_base))
      report_failure($sformatf("First round_start came %0d cycles after reset, expected %0d",
                               cycle_count - release_cycle, round_base));
    expected_gap = 0;
    last_strobe  = cycle_count;
    for (int r = 0; r <= n_rounds; r++)
    begin
      if (r > 0 && cycle_count - last_strobe != expected_gap)
        report_failure($sformatf("Round %0d lasted %0d cycles, expected %0d",
                                 r, cycle_count - last_strobe, expected_gap));
      last_strobe  = cycle_count;
      expected_gap = int'(round_base >> exp_level);  // Level before this update
      cur          = moles;
      if (!cur.valid)
        report_failure("moles.valid low in a round_start cycle");
      if (cur.first.row >= mole_geometry_pkg::grid_rows ||
          cur.second.row >= mole_geometry_pkg::grid_rows)
        report_failure($sformatf("Mole tile outside the grid at %0t", $time));
      score_round(exp_hits);
      @(negedge clock);
      check_score(score, exp_score);
      check_level(level, exp_level);
      check_level_up(level_up, exp_level_up);
      if (r < n_rounds)
      begin
        play_round(cur, actions[r], clears[r]);
        wait_strobe();
      end
    end
    $display("Rounds %0d, decoy penalties %0d, final level %0d",
             n_rounds, penalties, exp_level);
    $display("TB PASSED");
    $finish;
  end

  // Watchdog sized from the trace length
  initial
  begin : watchdog
    int limit;
    wait (trace_loaded);
    limit = actions.size() * 300 + 8;
    repeat (limit) @(posedge clock);
    report_failure($sformatf("Watchdog expired after %0d cycles, rounds did not finish",
                             limit));
  end

endmodule

// ==== tests/round_trace.txt ====
# action is none, first, second or both
# clear is 1 to clear the score after the action
none 0
first 0
second 1
both 0
second 0
both 0
none 1
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
first 0
both 0
second 0

// ==== files.f ====
+incdir+tests
source/mole_geometry_pkg.sv
source/mole_score_pkg.sv
source/mole_placer.sv
source/hit_latch.sv
source/score_keeper.sv
source/whack_a_mole.sv
tests/whack_a_mole_tb.sv
